// File: rob_pkg.sv
package rob_pkg;

    //////////////////////////////
    // geometry
    //////////////////////////////

    // log2 of the entry count
    localparam int ROB_WIDTH  = 6;
    localparam int AREG_WIDTH = 5;
    localparam int XLEN       = 32;

    //////////////////////////////
    // entry fields
    //////////////////////////////

    localparam int CTRL_WIDTH = 8;
    localparam int CODE_WIDTH = 6;

    // inst entry is areg, pc, w_reg, w_mem
    localparam int INST_WIDTH = AREG_WIDTH + XLEN + 2;
    // data entry is result plus control word
    localparam int DATA_WIDTH = XLEN + CTRL_WIDTH;

    // exception view, kind = 1
    typedef struct packed {
        logic                  kind;
        logic                  valid;
        logic [CODE_WIDTH-1:0] code;
    } rob_exc_view_t;

    // branch view, kind = 0
    typedef struct packed {
        logic                  kind;
        logic                  miss;
        logic [CODE_WIDTH-1:0] pred_idx;
    } rob_br_view_t;

    // one control word, two readings
    typedef union packed {
        rob_exc_view_t exc;
        rob_br_view_t  br;
    } rob_ctrl_u;

endpackage

// File: rob_apb_pkg.sv
package rob_apb_pkg;

    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    //////////////////////////////
    // register map
    //////////////////////////////

    localparam logic [APB_AW-1:0] REG_CTRL    = 8'h00;
    localparam logic [APB_AW-1:0] REG_STATUS  = 8'h04;
    localparam logic [APB_AW-1:0] REG_RETIRED = 8'h08;
    localparam logic [APB_AW-1:0] REG_EXC     = 8'h0C;
    localparam logic [APB_AW-1:0] REG_BRMISS  = 8'h10;

    // write 1 for a single flush pulse
    localparam int CTRL_FLUSH_BIT = 0;

endpackage

// File: rob_regfile.sv
module rob_regfile #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 64,
    parameter int R_PORTS    = 2,
    parameter int W_PORTS    = 2,
    parameter bit NEED_RESET = 1'b0,
    localparam int AW        = $clog2(DEPTH)
) (
    input  logic                                clk,
    input  logic                                rst_i,

    // combinational read side
    input  logic [R_PORTS-1:0][AW-1:0]          raddr_i,
    output logic [R_PORTS-1:0][DATA_WIDTH-1:0]  rdata_o,

    // edge write side
    input  logic [W_PORTS-1:0][AW-1:0]          waddr_i,
    input  logic [W_PORTS-1:0]                  we_i,
    input  logic [W_PORTS-1:0][DATA_WIDTH-1:0]  wdata_i
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // later ports overwrite earlier ones on a shared address
    always_ff @(posedge clk) begin
        if (NEED_RESET && rst_i) begin
            for (int e = 0; e < DEPTH; e++) begin
                mem[e] <= '0;
            end
        end else begin
            for (int w = 0; w < W_PORTS; w++) begin
                if (we_i[w]) begin
                    mem[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    // no write bypass
    always_comb begin
        for (int r = 0; r < R_PORTS; r++) begin
            rdata_o[r] = mem[raddr_i[r]];
        end
    end

endmodule

// File: rob_core.sv
module rob_core #(
    parameter int ROB_WIDTH = rob_pkg::ROB_WIDTH
) (
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic                                    flush_i,
    input  logic                                    csr_flush_i,

    // dispatch from rename
    input  logic [1:0]                              dispatch_issue_i,
    input  logic [1:0][ROB_WIDTH-1:0]               dispatch_slot_i,
    input  logic [1:0][rob_pkg::AREG_WIDTH-1:0]     dispatch_areg_i,
    input  logic [1:0][rob_pkg::XLEN-1:0]           dispatch_pc_i,
    input  logic [1:0]                              dispatch_w_reg_i,
    input  logic [1:0]                              dispatch_w_mem_i,
    input  logic [1:0][ROB_WIDTH-1:0]               dispatch_src0_slot_i,
    input  logic [1:0][ROB_WIDTH-1:0]               dispatch_src1_slot_i,
    output logic [1:0][rob_pkg::XLEN-1:0]           src0_data_o,
    output logic [1:0][rob_pkg::XLEN-1:0]           src1_data_o,
    output logic [1:0]                              src0_complete_o,
    output logic [1:0]                              src1_complete_o,
    output logic [ROB_WIDTH:0]                      rob_free_o,

    // result bus
    input  logic [1:0]                              cdb_valid_i,
    input  logic [1:0][ROB_WIDTH-1:0]               cdb_slot_i,
    input  logic [1:0][rob_pkg::XLEN-1:0]           cdb_data_i,
    input  logic [1:0][rob_pkg::CTRL_WIDTH-1:0]     cdb_ctrl_i,

    // commit, lane 0 is oldest
    output logic [1:0]                              commit_valid_o,
    output logic [1:0][rob_pkg::AREG_WIDTH-1:0]     commit_areg_o,
    output logic [1:0][rob_pkg::XLEN-1:0]           commit_pc_o,
    output logic [1:0][rob_pkg::XLEN-1:0]           commit_data_o,
    output logic [1:0][rob_pkg::CTRL_WIDTH-1:0]     commit_ctrl_o,
    output logic [1:0]                              commit_w_reg_o,
    output logic [1:0]                              commit_w_mem_o,
    input  logic [1:0]                              commit_req_i,

    // towards the register block
    output logic [ROB_WIDTH:0]                      rob_count_o,
    output logic [1:0]                              retire_valid_o,
    output logic [1:0][rob_pkg::CTRL_WIDTH-1:0]     retire_ctrl_o
);

    localparam int DEPTH  = 1 << ROB_WIDTH;
    localparam int INST_W = rob_pkg::INST_WIDTH;
    localparam int DATA_W = rob_pkg::DATA_WIDTH;

    logic                       flush;
    logic [1:0]                 n_disp;
    logic [1:0]                 n_commit;
    logic [ROB_WIDTH-1:0]       oldest_q;
    logic [ROB_WIDTH:0]         count_q;
    logic [1:0][ROB_WIDTH-1:0]  commit_slot;

    logic [1:0][INST_W-1:0]     disp_inst;
    logic [1:0][INST_W-1:0]     commit_inst;
    logic [1:0][DATA_W-1:0]     cdb_wdata;
    logic [1:0][DATA_W-1:0]     commit_rd;
    logic [1:0][DATA_W-1:0]     src0_rd;
    logic [1:0][DATA_W-1:0]     src1_rd;

    // dispatch-side and cdb-side completion bits
    logic [1:0] disp_commit, disp_src0, disp_src1, disp_at_cdb;
    logic [1:0] cdb_commit, cdb_src0, cdb_src1, cdb_at_disp;

    //////////////////////////////
    // pointers and occupancy
    //////////////////////////////

    assign flush    = flush_i | csr_flush_i;
    assign n_disp   = dispatch_issue_i[0] + dispatch_issue_i[1];
    assign n_commit = commit_req_i[0] + commit_req_i[1];

    always_ff @(posedge clk) begin
        if (rst_i || flush) begin
            oldest_q <= '0;
            count_q  <= '0;
        end else begin
            oldest_q <= oldest_q + ROB_WIDTH'(n_commit);
            count_q  <= count_q + (ROB_WIDTH+1)'(n_disp) - (ROB_WIDTH+1)'(n_commit);
        end
    end

    assign commit_slot[0] = oldest_q;
    assign commit_slot[1] = oldest_q + ROB_WIDTH'(1);
    assign rob_count_o    = count_q;
    assign rob_free_o     = (ROB_WIDTH+1)'(DEPTH) - count_q;

    //////////////////////////////
    // entry tables
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            disp_inst[i] = {dispatch_areg_i[i], dispatch_pc_i[i],
                            dispatch_w_reg_i[i], dispatch_w_mem_i[i]};
            cdb_wdata[i] = {cdb_data_i[i], cdb_ctrl_i[i]};
            {commit_areg_o[i], commit_pc_o[i], commit_w_reg_o[i], commit_w_mem_o[i]} =
                commit_inst[i];
            {commit_data_o[i], commit_ctrl_o[i]} = commit_rd[i];
            // ctrl part of a source read is dropped
            src0_data_o[i] = src0_rd[i][DATA_W-1 -: rob_pkg::XLEN];
            src1_data_o[i] = src1_rd[i][DATA_W-1 -: rob_pkg::XLEN];
        end
    end

    rob_regfile #(
        .DATA_WIDTH(INST_W), .DEPTH(DEPTH), .R_PORTS(2), .W_PORTS(2), .NEED_RESET(1'b0)
    ) inst_table (
        .clk, .rst_i,
        .raddr_i(commit_slot),
        .rdata_o(commit_inst),
        .waddr_i(dispatch_slot_i),
        .we_i(dispatch_issue_i),
        .wdata_i(disp_inst)
    );

    rob_regfile #(
        .DATA_WIDTH(DATA_W), .DEPTH(DEPTH), .R_PORTS(6), .W_PORTS(2), .NEED_RESET(1'b0)
    ) data_table (
        .clk, .rst_i,
        .raddr_i({dispatch_src1_slot_i, dispatch_src0_slot_i, commit_slot}),
        .rdata_o({src1_rd, src0_rd, commit_rd}),
        .waddr_i(cdb_slot_i),
        .we_i(cdb_valid_i),
        .wdata_i(cdb_wdata)
    );

    //////////////////////////////
    // completion
    //////////////////////////////

    // dispatch copies the cdb bit so the pair matches, meaning not done
    rob_regfile #(
        .DATA_WIDTH(1), .DEPTH(DEPTH), .R_PORTS(8), .W_PORTS(2), .NEED_RESET(1'b1)
    ) disp_bit_table (
        .clk, .rst_i,
        .raddr_i({cdb_slot_i, dispatch_src1_slot_i, dispatch_src0_slot_i, commit_slot}),
        .rdata_o({disp_at_cdb, disp_src1, disp_src0, disp_commit}),
        .waddr_i(dispatch_slot_i),
        .we_i(dispatch_issue_i),
        .wdata_i(cdb_at_disp)
    );

    // cdb writes the inverse so the pair differs
    rob_regfile #(
        .DATA_WIDTH(1), .DEPTH(DEPTH), .R_PORTS(8), .W_PORTS(2), .NEED_RESET(1'b1)
    ) cdb_bit_table (
        .clk, .rst_i,
        .raddr_i({dispatch_slot_i, dispatch_src1_slot_i, dispatch_src0_slot_i, commit_slot}),
        .rdata_o({cdb_at_disp, cdb_src1, cdb_src0, cdb_commit}),
        .waddr_i(cdb_slot_i),
        .we_i(cdb_valid_i),
        .wdata_i(~disp_at_cdb)
    );

    assign src0_complete_o   = disp_src0 ^ cdb_src0;
    assign src1_complete_o   = disp_src1 ^ cdb_src1;
    assign commit_valid_o[0] = (disp_commit[0] ^ cdb_commit[0]) & (count_q > 0);
    assign commit_valid_o[1] = (disp_commit[1] ^ cdb_commit[1]) & (count_q > 1);

    assign retire_valid_o = commit_req_i & commit_valid_o;
    assign retire_ctrl_o  = commit_ctrl_o;

endmodule

// File: rob_csr.sv
module rob_csr #(
    parameter int ROB_WIDTH = rob_pkg::ROB_WIDTH
) (
    input  logic                                    clk,
    input  logic                                    rst_i,

    // apb slave
    input  logic                                    psel_i,
    input  logic                                    penable_i,
    input  logic                                    pwrite_i,
    input  logic [rob_apb_pkg::APB_AW-1:0]          paddr_i,
    input  logic [rob_apb_pkg::APB_DW-1:0]          pwdata_i,
    output logic [rob_apb_pkg::APB_DW-1:0]          prdata_o,
    output logic                                    pready_o,
    output logic                                    pslverr_o,

    // rob side
    input  logic [ROB_WIDTH:0]                      rob_count_i,
    input  logic [1:0]                              retire_valid_i,
    input  logic [1:0][rob_pkg::CTRL_WIDTH-1:0]     retire_ctrl_i,
    output logic                                    csr_flush_o
);

    logic                                   wr_en;
    logic                                   addr_ok;
    logic                                   ro_hit;
    logic [1:0]                             exc_hit;
    logic [1:0]                             miss_hit;
    rob_pkg::rob_ctrl_u [1:0]               ctrl_view;
    logic [rob_apb_pkg::APB_DW-1:0]         retired_q, exc_q, brmiss_q;

    assign wr_en    = psel_i & penable_i & pwrite_i;
    assign pready_o = 1'b1;

    //////////////////////////////
    // retire decode
    //////////////////////////////

    assign ctrl_view = retire_ctrl_i;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            exc_hit[i]  = retire_valid_i[i] & ctrl_view[i].exc.kind & ctrl_view[i].exc.valid;
            miss_hit[i] = retire_valid_i[i] & ~ctrl_view[i].br.kind & ctrl_view[i].br.miss;
        end
    end

    // a write to a counter clears it, whatever the data
    always_ff @(posedge clk) begin
        if (rst_i) begin
            retired_q   <= '0;
            exc_q       <= '0;
            brmiss_q    <= '0;
            csr_flush_o <= 1'b0;
        end else begin
            csr_flush_o <= wr_en && paddr_i == rob_apb_pkg::REG_CTRL &&
                           pwdata_i[rob_apb_pkg::CTRL_FLUSH_BIT];
            if (wr_en && paddr_i == rob_apb_pkg::REG_RETIRED) retired_q <= '0;
            else retired_q <= retired_q + retire_valid_i[0] + retire_valid_i[1];
            if (wr_en && paddr_i == rob_apb_pkg::REG_EXC) exc_q <= '0;
            else exc_q <= exc_q + exc_hit[0] + exc_hit[1];
            if (wr_en && paddr_i == rob_apb_pkg::REG_BRMISS) brmiss_q <= '0;
            else brmiss_q <= brmiss_q + miss_hit[0] + miss_hit[1];
        end
    end

    //////////////////////////////
    // read mux and errors
    //////////////////////////////

    always_comb begin
        prdata_o = '0;
        addr_ok  = 1'b1;
        ro_hit   = 1'b0;
        case (paddr_i)
            rob_apb_pkg::REG_CTRL:    prdata_o = '0;
            rob_apb_pkg::REG_STATUS: begin
                prdata_o = rob_apb_pkg::APB_DW'(rob_count_i);
                ro_hit   = 1'b1;
            end
            rob_apb_pkg::REG_RETIRED: prdata_o = retired_q;
            rob_apb_pkg::REG_EXC:     prdata_o = exc_q;
            rob_apb_pkg::REG_BRMISS:  prdata_o = brmiss_q;
            default:                  addr_ok  = 1'b0;
        endcase
    end

    assign pslverr_o = psel_i & penable_i & (~addr_ok | (pwrite_i & ro_hit));

endmodule

// File: rob_top.sv
module rob_top #(
    parameter int ROB_WIDTH = rob_pkg::ROB_WIDTH
) (
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic                                    flush_i,

    // dispatch
    input  logic [1:0]                              dispatch_issue_i,
    input  logic [1:0][ROB_WIDTH-1:0]               dispatch_slot_i,
    input  logic [1:0][rob_pkg::AREG_WIDTH-1:0]     dispatch_areg_i,
    input  logic [1:0][rob_pkg::XLEN-1:0]           dispatch_pc_i,
    input  logic [1:0]                              dispatch_w_reg_i,
    input  logic [1:0]                              dispatch_w_mem_i,
    input  logic [1:0][ROB_WIDTH-1:0]               dispatch_src0_slot_i,
    input  logic [1:0][ROB_WIDTH-1:0]               dispatch_src1_slot_i,
    output logic [1:0][rob_pkg::XLEN-1:0]           src0_data_o,
    output logic [1:0][rob_pkg::XLEN-1:0]           src1_data_o,
    output logic [1:0]                              src0_complete_o,
    output logic [1:0]                              src1_complete_o,
    output logic [ROB_WIDTH:0]                      rob_free_o,

    // cdb
    input  logic [1:0]                              cdb_valid_i,
    input  logic [1:0][ROB_WIDTH-1:0]               cdb_slot_i,
    input  logic [1:0][rob_pkg::XLEN-1:0]           cdb_data_i,
    input  logic [1:0][rob_pkg::CTRL_WIDTH-1:0]     cdb_ctrl_i,

    // commit
    output logic [1:0]                              commit_valid_o,
    output logic [1:0][rob_pkg::AREG_WIDTH-1:0]     commit_areg_o,
    output logic [1:0][rob_pkg::XLEN-1:0]           commit_pc_o,
    output logic [1:0][rob_pkg::XLEN-1:0]           commit_data_o,
    output logic [1:0][rob_pkg::CTRL_WIDTH-1:0]     commit_ctrl_o,
    output logic [1:0]                              commit_w_reg_o,
    output logic [1:0]                              commit_w_mem_o,
    input  logic [1:0]                              commit_req_i,

    // apb
    input  logic                                    psel_i,
    input  logic                                    penable_i,
    input  logic                                    pwrite_i,
    input  logic [rob_apb_pkg::APB_AW-1:0]          paddr_i,
    input  logic [rob_apb_pkg::APB_DW-1:0]          pwdata_i,
    output logic [rob_apb_pkg::APB_DW-1:0]          prdata_o,
    output logic                                    pready_o,
    output logic                                    pslverr_o
);

    logic                               csr_flush;
    logic [ROB_WIDTH:0]                 rob_count;
    logic [1:0]                         retire_valid;
    logic [1:0][rob_pkg::CTRL_WIDTH-1:0] retire_ctrl;

    rob_core #(
        .ROB_WIDTH(ROB_WIDTH)
    ) core0 (
        .clk, .rst_i, .flush_i,
        .csr_flush_i(csr_flush),
        .dispatch_issue_i, .dispatch_slot_i, .dispatch_areg_i, .dispatch_pc_i,
        .dispatch_w_reg_i, .dispatch_w_mem_i,
        .dispatch_src0_slot_i, .dispatch_src1_slot_i,
        .src0_data_o, .src1_data_o, .src0_complete_o, .src1_complete_o,
        .rob_free_o,
        .cdb_valid_i, .cdb_slot_i, .cdb_data_i, .cdb_ctrl_i,
        .commit_valid_o, .commit_areg_o, .commit_pc_o, .commit_data_o,
        .commit_ctrl_o, .commit_w_reg_o, .commit_w_mem_o, .commit_req_i,
        .rob_count_o(rob_count),
        .retire_valid_o(retire_valid),
        .retire_ctrl_o(retire_ctrl)
    );

    rob_csr #(
        .ROB_WIDTH(ROB_WIDTH)
    ) csr0 (
        .clk, .rst_i,
        .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .rob_count_i(rob_count),
        .retire_valid_i(retire_valid),
        .retire_ctrl_i(retire_ctrl),
        .csr_flush_o(csr_flush)
    );

endmodule

// File: rob_chk.sv
module rob_chk #(
    parameter int ROB_WIDTH = rob_pkg::ROB_WIDTH
) (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic [1:0]                  commit_req_i,
    input  logic [1:0]                  commit_valid_i,
    input  logic [ROB_WIDTH:0]          count_i,
    input  logic [ROB_WIDTH-1:0]        oldest_i,
    input  logic [1:0]                  cdb_valid_i,
    input  logic [1:0][ROB_WIDTH-1:0]   cdb_slot_i
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 1 << ROB_WIDTH;

    // distance of each cdb slot from the oldest entry
    logic [1:0][ROB_WIDTH-1:0] cdb_off;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            cdb_off[i] = cdb_slot_i[i] - oldest_i;
        end
    end

    lane_order: assert property (@(posedge clk) disable iff (rst_i)
        commit_req_i[1] |-> commit_req_i[0])
        else $error("commit lane 1 requested without lane 0");

    commit_ready: assert property (@(posedge clk) disable iff (rst_i)
        (commit_req_i & ~commit_valid_i) == 2'b00)
        else $error("commit requested on a lane that is not valid");

    count_limit: assert property (@(posedge clk) disable iff (rst_i)
        count_i <= (ROB_WIDTH+1)'(DEPTH))
        else $error("occupancy count above the rob depth");

    cdb_occupied0: assert property (@(posedge clk) disable iff (rst_i)
        cdb_valid_i[0] |-> count_i > (ROB_WIDTH+1)'(cdb_off[0]))
        else $error("cdb lane 0 wrote a free slot");

    cdb_occupied1: assert property (@(posedge clk) disable iff (rst_i)
        cdb_valid_i[1] |-> count_i > (ROB_WIDTH+1)'(cdb_off[1]))
        else $error("cdb lane 1 wrote a free slot");

endmodule

// File: rob_tb.sv
module rob_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROB_WIDTH      = rob_pkg::ROB_WIDTH;
    localparam int DEPTH          = 1 << ROB_WIDTH;
    localparam int TRAFFIC_CYCLES = 2000;
    localparam int SHORT_CYCLES   = 200;
    localparam int TOTAL_CYCLES   = 10 + TRAFFIC_CYCLES + SHORT_CYCLES + 100;

    logic                       clk;
    logic                       rst_i;
    logic                       flush_i;
    logic [1:0]                 dispatch_issue_i;
    logic [1:0][ROB_WIDTH-1:0]  dispatch_slot_i;
    logic [1:0][4:0]            dispatch_areg_i;
    logic [1:0][31:0]           dispatch_pc_i;
    logic [1:0]                 dispatch_w_reg_i;
    logic [1:0]                 dispatch_w_mem_i;
    logic [1:0][ROB_WIDTH-1:0]  dispatch_src0_slot_i;
    logic [1:0][ROB_WIDTH-1:0]  dispatch_src1_slot_i;
    logic [1:0][31:0]           src0_data_o;
    logic [1:0][31:0]           src1_data_o;
    logic [1:0]                 src0_complete_o;
    logic [1:0]                 src1_complete_o;
    logic [ROB_WIDTH:0]         rob_free_o;
    logic [1:0]                 cdb_valid_i;
    logic [1:0][ROB_WIDTH-1:0]  cdb_slot_i;
    logic [1:0][31:0]           cdb_data_i;
    logic [1:0][7:0]            cdb_ctrl_i;
    logic [1:0]                 commit_valid_o;
    logic [1:0][4:0]            commit_areg_o;
    logic [1:0][31:0]           commit_pc_o;
    logic [1:0][31:0]           commit_data_o;
    logic [1:0][7:0]            commit_ctrl_o;
    logic [1:0]                 commit_w_reg_o;
    logic [1:0]                 commit_w_mem_o;
    logic [1:0]                 commit_req_i;
    logic                       psel_i;
    logic                       penable_i;
    logic                       pwrite_i;
    logic [7:0]                 paddr_i;
    logic [31:0]                pwdata_i;
    logic [31:0]                prdata_o;
    logic                       pready_o;
    logic                       pslverr_o;

    // reference copy of every slot
    logic [4:0]                 m_areg [DEPTH];
    logic [31:0]                m_pc [DEPTH];
    logic [31:0]                m_data [DEPTH];
    logic [7:0]                 m_ctrl [DEPTH];
    logic                       m_wreg [DEPTH];
    logic                       m_wmem [DEPTH];
    logic                       m_done [DEPTH];
    logic [ROB_WIDTH-1:0]       m_head;
    int                         m_count;
    int unsigned                m_retired;
    int unsigned                m_exc;
    int unsigned                m_brmiss;
    logic [31:0]                rng;

    rob_top #(.ROB_WIDTH(ROB_WIDTH)) dut0 (.*);

    bind rob_core rob_chk #(.ROB_WIDTH(ROB_WIDTH)) chk0 (
        .clk(clk), .rst_i(rst_i), .commit_req_i(commit_req_i),
        .commit_valid_i(commit_valid_o), .count_i(count_q), .oldest_i(oldest_q),
        .cdb_valid_i(cdb_valid_i), .cdb_slot_i(cdb_slot_i)
    );

    always #5 clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic stop_on_error();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("error: %s expected 0x%08h actual 0x%08h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic init_inputs();
        clk = 1'b0;
        rst_i = 1'b1;
        flush_i = 1'b0;
        dispatch_issue_i = '0;
        dispatch_slot_i = '0;
        dispatch_areg_i = '0;
        dispatch_pc_i = '0;
        dispatch_w_reg_i = '0;
        dispatch_w_mem_i = '0;
        dispatch_src0_slot_i = '0;
        dispatch_src1_slot_i = '0;
        cdb_valid_i = '0;
        cdb_slot_i = '0;
        cdb_data_i = '0;
        cdb_ctrl_i = '0;
        commit_req_i = '0;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = '0;
        pwdata_i = '0;
        for (int e = 0; e < DEPTH; e++) begin
            m_done[e] = 1'b0;
        end
        m_head = '0;
        m_count = 0;
        m_retired = 0;
        m_exc = 0;
        m_brmiss = 0;
        rng = 32'hd1c731a9;
    endtask

    //////////////////////////////
    // rob model and traffic
    //////////////////////////////

    // inputs still hold what the dut sampled at this edge
    task automatic apply_edge();
        logic [ROB_WIDTH-1:0] s;
        int n;
        n = 0;
        for (int i = 0; i < 2; i++) begin
            if (commit_req_i[i]) begin
                s = m_head + ROB_WIDTH'(i);
                m_retired++;
                // bit 7 picks the view and bit 6 is valid or miss
                if (m_ctrl[s][7] && m_ctrl[s][6]) m_exc++;
                if (!m_ctrl[s][7] && m_ctrl[s][6]) m_brmiss++;
                n++;
            end
            if (dispatch_issue_i[i]) begin
                s = dispatch_slot_i[i];
                m_areg[s] = dispatch_areg_i[i];
                m_pc[s] = dispatch_pc_i[i];
                m_wreg[s] = dispatch_w_reg_i[i];
                m_wmem[s] = dispatch_w_mem_i[i];
                m_done[s] = 1'b0;
                m_count++;
            end
            if (cdb_valid_i[i]) begin
                s = cdb_slot_i[i];
                m_data[s] = cdb_data_i[i];
                m_ctrl[s] = cdb_ctrl_i[i];
                m_done[s] = 1'b1;
            end
        end
        m_head = m_head + ROB_WIDTH'(n);
        m_count = m_count - n;
    endtask

    task automatic drive_next(input bit quiet);
        logic [31:0] r;
        logic [ROB_WIDTH-1:0] s;
        logic [1:0] cvalid;
        logic [1:0][ROB_WIDTH-1:0] cslot;
        int nd;
        int off;
        r = next_random();
        nd = quiet ? 0 : int'(r[1:0]);
        if (nd > 2) nd = 2;
        if (nd > DEPTH - m_count) nd = DEPTH - m_count;
        cvalid = '0;
        cslot = '0;
        for (int i = 0; i < 2; i++) begin
            dispatch_issue_i[i] <= (nd > i);
            dispatch_slot_i[i] <= m_head + ROB_WIDTH'(m_count + i);
            dispatch_areg_i[i] <= 5'(next_random());
            dispatch_pc_i[i] <= next_random();
            r = next_random();
            dispatch_w_reg_i[i] <= r[0];
            dispatch_w_mem_i[i] <= r[1];
            dispatch_src0_slot_i[i] <= ROB_WIDTH'(r[15:8]);
            dispatch_src1_slot_i[i] <= ROB_WIDTH'(r[23:16]);
            // complete a random pending entry
            r = next_random();
            if (!quiet && m_count > 0 && r[1:0] != 2'b00) begin
                off = int'(r[31:8]) % m_count;
                s = m_head + ROB_WIDTH'(off);
                if (!m_done[s] && !(i == 1 && cvalid[0] && cslot[0] == s)) begin
                    cvalid[i] = 1'b1;
                    cslot[i] = s;
                end
            end
            cdb_data_i[i] <= next_random();
            cdb_ctrl_i[i] <= 8'(next_random());
        end
        cdb_valid_i <= cvalid;
        cdb_slot_i <= cslot;
        // retire in order as soon as the oldest is done
        commit_req_i[0] <= !quiet && m_count > 0 && m_done[m_head];
        commit_req_i[1] <= !quiet && m_count > 1 && m_done[m_head]
                           && m_done[m_head + ROB_WIDTH'(1)];
    endtask

    task automatic check_outputs();
        logic [ROB_WIDTH-1:0] s;
        logic exp_v;
        check_val("rob_free_o", DEPTH - m_count, 32'(rob_free_o));
        for (int i = 0; i < 2; i++) begin
            s = m_head + ROB_WIDTH'(i);
            exp_v = (m_count > i) && m_done[s];
            check_val($sformatf("commit_valid_o[%0d]", i), 32'(exp_v), 32'(commit_valid_o[i]));
            if (exp_v) begin
                check_val($sformatf("commit_areg_o[%0d]", i), 32'(m_areg[s]),
                          32'(commit_areg_o[i]));
                check_val($sformatf("commit_pc_o[%0d]", i), m_pc[s], commit_pc_o[i]);
                check_val($sformatf("commit_data_o[%0d]", i), m_data[s], commit_data_o[i]);
                check_val($sformatf("commit_ctrl_o[%0d]", i), 32'(m_ctrl[s]),
                          32'(commit_ctrl_o[i]));
                check_val($sformatf("commit_w_reg_o[%0d]", i), 32'(m_wreg[s]),
                          32'(commit_w_reg_o[i]));
                check_val($sformatf("commit_w_mem_o[%0d]", i), 32'(m_wmem[s]),
                          32'(commit_w_mem_o[i]));
            end
            s = dispatch_src0_slot_i[i];
            check_val($sformatf("src0_complete_o[%0d]", i), 32'(m_done[s]),
                      32'(src0_complete_o[i]));
            if (m_done[s]) check_val($sformatf("src0_data_o[%0d]", i), m_data[s], src0_data_o[i]);
            s = dispatch_src1_slot_i[i];
            check_val($sformatf("src1_complete_o[%0d]", i), 32'(m_done[s]),
                      32'(src1_complete_o[i]));
            if (m_done[s]) check_val($sformatf("src1_data_o[%0d]", i), m_data[s], src1_data_o[i]);
        end
    endtask

    task automatic step(input bit quiet);
        @(posedge clk);
        apply_edge();
        drive_next(quiet);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic flush_by_pin();
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        m_head = '0;
        m_count = 0;
        @(negedge clk);
        check_outputs();
    endtask

    //////////////////////////////
    // apb
    //////////////////////////////

    task automatic apb_access(input bit write, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel_i <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i <= write;
        paddr_i <= addr;
        pwdata_i <= wdata;
        @(posedge clk);
        penable_i <= 1'b1;
        @(negedge clk);
        while (!pready_o) @(negedge clk);
        rdata = prdata_o;
        err = pslverr_o;
        @(posedge clk);
        psel_i <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic apb_expect(input bit write, input logic [7:0] addr, input logic [31:0] wdata,
                              input logic [31:0] exp_rd, input logic exp_err);
        logic [31:0] rd;
        logic err;
        apb_access(write, addr, wdata, rd, err);
        check_val($sformatf("pslverr_o@%02h", addr), 32'(exp_err), 32'(err));
        if (!write && !exp_err) check_val($sformatf("prdata_o@%02h", addr), exp_rd, rd);
    endtask

    task automatic check_stats();
        apb_expect(1'b0, rob_apb_pkg::REG_RETIRED, '0, m_retired, 1'b0);
        apb_expect(1'b0, rob_apb_pkg::REG_EXC, '0, m_exc, 1'b0);
        apb_expect(1'b0, rob_apb_pkg::REG_BRMISS, '0, m_brmiss, 1'b0);
    endtask

    //////////////////////////////
    // sequence
    //////////////////////////////

    initial begin
        init_inputs();
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_outputs();
        check_stats();
        apb_expect(1'b0, rob_apb_pkg::REG_STATUS, '0, '0, 1'b0);

        repeat (TRAFFIC_CYCLES) step(1'b0);
        step(1'b1);
        check_stats();

        // any write clears a counter
        apb_expect(1'b1, rob_apb_pkg::REG_RETIRED, 32'hffff_ffff, '0, 1'b0);
        apb_expect(1'b1, rob_apb_pkg::REG_EXC, 32'h1234_5678, '0, 1'b0);
        apb_expect(1'b1, rob_apb_pkg::REG_BRMISS, 32'h0, '0, 1'b0);
        m_retired = 0;
        m_exc = 0;
        m_brmiss = 0;
        check_stats();

        flush_by_pin();
        repeat (SHORT_CYCLES) step(1'b0);
        step(1'b1);
        apb_expect(1'b0, rob_apb_pkg::REG_STATUS, '0, 32'(m_count), 1'b0);

        // flush pulse follows the access edge and the pointers clear one edge later
        apb_expect(1'b1, rob_apb_pkg::REG_CTRL, 32'h1, '0, 1'b0);
        @(posedge clk);
        m_head = '0;
        m_count = 0;
        @(negedge clk);
        check_outputs();

        apb_expect(1'b0, 8'h14, '0, '0, 1'b1);
        apb_expect(1'b1, rob_apb_pkg::REG_STATUS, 32'h5, '0, 1'b1);

        $display("All tests passed!");
        $finish;
    end

    initial begin
        #(TOTAL_CYCLES * 2 * 10);
        $display("timeout: the run went past its cycle budget");
        $display("Test failures found");
        $fatal(1);
    end

endmodule

// File: rob_subsys.f
rob_pkg.sv
rob_apb_pkg.sv
rob_regfile.sv
rob_core.sv
rob_csr.sv
rob_top.sv
rob_chk.sv
rob_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rob_tb
FLIST     ?= rob_subsys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
